/* spi_quad_master.f */
+incdir+logic
logic/spi_types_pkg.sv
logic/spi_ctrl_pkg.sv
logic/spi_lane_if.sv
logic/spi_frame_ctrl.sv
logic/spi_lane_shifter.sv
logic/spi_rx_assembler.sv
logic/spi_quad_master.sv
test/spi_slave_model.sv
test/tb_spi_quad_master.sv

/* Makefile */
# Verilator build and run for the quad SPI master testbench

SIM = obj_dir/Vtb_spi_quad_master

.PHONY: all run clean

all: run

$(SIM): spi_quad_master.f $(wildcard logic/*.sv logic/*.svh test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f spi_quad_master.f \
		--top-module tb_spi_quad_master

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test OK" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* test/tb_spi_quad_master.sv */
// directed testbench for the quad-lane SPI master
// runs frames against a behavioral slave and checks both data directions
`timescale 1ns/1ps
`include "spi_cfg.svh"

module tb_spi_quad_master
  import spi_types_pkg::*;
();

  // cycles allowed for any single wait
  localparam int WAIT_MAX = 400;

  logic                  sclk;
  logic                  arst_n;
  logic                  start;
  spi_word_t             tx_data;
  spi_sel_t              sel;
  logic                  cpol;
  logic                  cpha;
  logic [`SPI_LANES-1:0] miso;
  logic                  sck;
  spi_cs_t               cs_n;
  logic [`SPI_LANES-1:0] mosi;
  logic                  busy;
  spi_word_t             rx_data;
  logic                  done;
  spi_word_t             reply;
  spi_word_t             slave_rx;

  integer seed = 32'h83e47ebe;
  int     checks;
  int     errors;

  spi_quad_master dut0 (.*);

  spi_slave_model slave0 (
    .sclk    (sclk),
    .arst_n  (arst_n),
    .cs_n    (cs_n),
    .sel     (sel),
    .cpol    (cpol),
    .cpha    (cpha),
    .sck     (sck),
    .mosi    (mosi),
    .reply   (reply),
    .miso    (miso),
    .rx_word (slave_rx)
  );

  // 100 ns period
  initial begin
    sclk = 1'b0;
    forever #50 sclk = ~sclk;
  end

  // ------------------------------------------------------------
  // compares
  // ------------------------------------------------------------
  task automatic check_word(input string name, input spi_word_t got, input spi_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cs(input string name, input spi_cs_t got, input spi_cs_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic report(input string name, input int err0);
    $display("%-14s %s, %0d errors", name, (errors == err0) ? "passed" : "failed",
             errors - err0);
  endtask

  // ------------------------------------------------------------
  // frame helpers
  // ------------------------------------------------------------
  // one-cycle start strobe, frame settings held afterwards
  task automatic issue_start(input spi_word_t word, input spi_word_t rep, input spi_sel_t s,
                             input logic pol, input logic pha);
    @(posedge sclk);
    start   <= 1'b1;
    tx_data <= word;
    reply   <= rep;
    sel     <= s;
    cpol    <= pol;
    cpha    <= pha;
    @(posedge sclk);
    start <= 1'b0;
  endtask

  // looks at done on falling edges, bounded
  task automatic wait_done(input string name, output bit seen);
    seen = 1'b0;
    for (int n = 0; n < WAIT_MAX && !seen; n++) begin
      @(negedge sclk);
      seen = done;
    end
    if (!seen) begin
      errors++;
      $display("%0t %s: done never pulsed within %0d cycles", $time, name, WAIT_MAX);
    end
  endtask

  // slave sees tx word, master returns reply word
  task automatic run_frame(input string name, input spi_word_t word, input spi_word_t rep,
                           input spi_sel_t s, input logic pol, input logic pha);
    bit seen;
    issue_start(word, rep, s, pol, pha);
    wait_done(name, seen);
    if (seen) begin
      check_word("slave_rx", slave_rx, word);
      check_word("rx_data", rx_data, rep);
    end
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic test_reset();
    int err0;
    err0 = errors;
    arst_n <= 1'b0;
    repeat (8) @(posedge sclk);
    @(negedge sclk);
    check_cs("cs_n", cs_n, '1);
    check_bit("sck", sck, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    repeat (8) @(posedge sclk);
    arst_n <= 1'b1;
    repeat (4) @(negedge sclk);
    check_cs("cs_n", cs_n, '1);
    check_bit("sck", sck, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    report("reset_state", err0);
  endtask

  task automatic test_mode0();
    int err0;
    err0 = errors;
    run_frame("mode0", 32'hC3A5_5A3C, 32'h1E2D_3C4B, 2'd0, 1'b0, 1'b0);
    report("mode0", err0);
  endtask

  task automatic test_modes();
    int        err0;
    spi_word_t word;
    spi_word_t rep;
    err0 = errors;
    for (int m = 0; m < 4; m++) begin
      word = $random(seed);
      rep  = $random(seed);
      run_frame("modes", word, rep, 2'd1, m[1], m[0]);
      // sck parks at cpol between frames
      @(negedge sclk);
      check_bit("sck", sck, m[1]);
    end
    report("all_modes", err0);
  endtask

  task automatic test_select();
    int      err0;
    spi_cs_t exp;
    bit      seen;
    err0 = errors;
    for (int s = 0; s < `SPI_SLAVES; s++) begin
      exp    = '1;
      exp[s] = 1'b0;
      issue_start($random(seed), $random(seed), spi_sel_t'(s), 1'b0, 1'b0);
      seen = 1'b0;
      for (int n = 0; n < WAIT_MAX && !seen; n++) begin
        @(negedge sclk);
        seen = done;
        if (busy) check_cs("cs_n", cs_n, exp);
      end
      if (!seen) begin
        errors++;
        $display("%0t select: done never pulsed for slave %0d", $time, s);
      end else begin
        check_cs("cs_n", cs_n, '1);
      end
    end
    report("slave_select", err0);
  endtask

  task automatic test_busy_start();
    int        err0;
    spi_word_t word;
    spi_word_t rep;
    bit        seen;
    bit        extra;
    err0  = errors;
    word  = 32'h0F1E_2D3C;
    rep   = 32'h8877_6655;
    extra = 1'b0;
    issue_start(word, rep, 2'd2, 1'b1, 1'b1);
    repeat (20) @(posedge sclk);
    // second strobe mid-frame, must be dropped
    issue_start(~word, rep, 2'd2, 1'b1, 1'b1);
    wait_done("busy_start", seen);
    if (seen) begin
      check_word("slave_rx", slave_rx, word);
      check_word("rx_data", rx_data, rep);
    end
    // longer than a whole frame
    for (int n = 0; n < 120; n++) begin
      @(negedge sclk);
      if (done) extra = 1'b1;
    end
    check_bit("second done", extra, 1'b0);
    check_bit("busy", busy, 1'b0);
    report("busy_start", err0);
  endtask

  task automatic test_back_to_back();
    int        err0;
    int        r;
    spi_word_t word;
    spi_word_t rep;
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      word = $random(seed);
      rep  = $random(seed);
      r    = $random(seed);
      run_frame("back_to_back", word, rep, spi_sel_t'(r[1:0]), r[2], r[3]);
    end
    report("back_to_back", err0);
  endtask

  // ------------------------------------------------------------
  // sequence
  // ------------------------------------------------------------
  initial begin
    arst_n  = 1'b0;
    start   = 1'b0;
    tx_data = '0;
    sel     = '0;
    cpol    = 1'b0;
    cpha    = 1'b0;
    reply   = '0;
    checks  = 0;
    errors  = 0;
    test_reset();
    test_mode0();
    test_modes();
    test_select();
    test_busy_start();
    test_back_to_back();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* test/spi_slave_model.sv */
// behavioral quad SPI slave for the master testbench
// oversamples cs_n and sck on sclk, records mosi, returns a preset reply word
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_slave_model
  import spi_types_pkg::*;
(
  input  logic                  sclk,
  input  logic                  arst_n,
  input  spi_cs_t               cs_n,
  input  spi_sel_t              sel,
  input  logic                  cpol,
  input  logic                  cpha,
  input  logic                  sck,
  input  logic [`SPI_LANES-1:0] mosi,
  input  spi_word_t             reply,
  output logic [`SPI_LANES-1:0] miso,
  output spi_word_t             rx_word
);

  localparam int BYTE_BITS = $bits(spi_byte_t);

  spi_byte_t tx_sh [`SPI_LANES];
  spi_byte_t rx_sh [`SPI_LANES];
  logic      sck_d;
  logic      act_d;
  int        edge_n;
  logic      act;
  logic      sck_edge;
  logic      lead;

  // our select low
  assign act      = ~cs_n[sel];
  // edges only count once select was already low a cycle
  assign sck_edge = act && act_d && (sck != sck_d);
  // leading edge leaves the idle level
  assign lead     = (sck != cpol);

  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      sck_d  <= 1'b0;
      act_d  <= 1'b0;
      edge_n <= 0;
      for (int j = 0; j < `SPI_LANES; j++) begin
        tx_sh[j] <= '0;
        rx_sh[j] <= '0;
      end
    end else begin
      sck_d <= sck;
      act_d <= act;
      if (act && !act_d) begin
        // select fell, msb of each reply byte goes out
        edge_n <= 0;
        for (int j = 0; j < `SPI_LANES; j++) tx_sh[j] <= reply[j*BYTE_BITS +: BYTE_BITS];
      end else if (sck_edge) begin
        edge_n <= edge_n + 1;
        for (int j = 0; j < `SPI_LANES; j++) begin
          // cpha0 samples leading, cpha1 trailing
          if (lead ^ cpha)
            rx_sh[j] <= {rx_sh[j][BYTE_BITS-2:0], mosi[j]};
          else if (!(cpha && edge_n == 0))
            tx_sh[j] <= {tx_sh[j][BYTE_BITS-2:0], 1'b0};
        end
      end
    end
  end

  for (genvar j = 0; j < `SPI_LANES; j++) begin : g_lane
    assign miso[j] = tx_sh[j][BYTE_BITS-1];
    assign rx_word[j*BYTE_BITS +: BYTE_BITS] = rx_sh[j];
  end

endmodule

/* logic/spi_quad_master.sv */
// quad-lane SPI master top level with plain ports
// one start strobe sends tx_data on four lanes and returns rx_data at done
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_quad_master
  import spi_types_pkg::*;
(
  input  logic                  sclk,
  input  logic                  arst_n,
  input  logic                  start,
  input  spi_word_t             tx_data,
  input  spi_sel_t              sel,
  input  logic                  cpol,
  input  logic                  cpha,
  input  logic [`SPI_LANES-1:0] miso,
  output logic                  sck,
  output spi_cs_t               cs_n,
  output logic [`SPI_LANES-1:0] mosi,
  output logic                  busy,
  output spi_word_t             rx_data,
  output logic                  done
);

  spi_lane_if lane_bus ();

  // per-lane rx bytes into the assembler
  spi_byte_t lane_rx [`SPI_LANES];

  spi_frame_ctrl ctrl0 (
    .sclk    (sclk),
    .arst_n  (arst_n),
    .start   (start),
    .tx_data (tx_data),
    .sel     (sel),
    .cpol    (cpol),
    .cpha    (cpha),
    .sck     (sck),
    .cs_n    (cs_n),
    .busy    (busy),
    .lanes   (lane_bus.ctrl)
  );

  // ------------------------------------------------------------
  // lanes
  // ------------------------------------------------------------
  for (genvar j = 0; j < `SPI_LANES; j++) begin : g_lane
    spi_lane_shifter #(.LANE(j)) lane (
      .sclk    (sclk),
      .arst_n  (arst_n),
      .bus     (lane_bus.lane),
      .miso    (miso[j]),
      .mosi    (mosi[j]),
      .rx_byte (lane_rx[j])
    );
  end

  spi_rx_assembler asm0 (
    .sclk     (sclk),
    .arst_n   (arst_n),
    .bus      (lane_bus.drain),
    .rx_bytes (lane_rx),
    .rx_data  (rx_data),
    .done     (done)
  );

endmodule

/* logic/spi_rx_assembler.sv */
// builds the received word from the lane bytes at frame end
// rx_data holds until the next done pulse
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_rx_assembler
  import spi_types_pkg::*;
(
  input  logic      sclk,
  input  logic      arst_n,
  spi_lane_if.drain bus,
  input  spi_byte_t rx_bytes [`SPI_LANES],
  output spi_word_t rx_data,
  output logic      done
);

  localparam int BYTE_BITS = $bits(spi_byte_t);

  spi_word_t word;

  // lane j lands in byte j
  for (genvar j = 0; j < `SPI_LANES; j++) begin : g_pack
    assign word[j*BYTE_BITS +: BYTE_BITS] = rx_bytes[j];
  end

  always_ff @(posedge sclk) begin
    if (bus.frame_end) rx_data <= word;
  end

  // done lines up with the new rx_data
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) done <= 1'b0;
    else done <= bus.frame_end;
  end

  a_done_pulse: assert property (@(posedge sclk) disable iff (!arst_n) done |=> !done);

endmodule

/* logic/spi_lane_shifter.sv */
// one SPI data lane, msb first
// shifts its tx byte out on mosi and collects miso into rx_byte
`timescale 1ns/1ps

module spi_lane_shifter
  import spi_types_pkg::*;
#(
  parameter int LANE = 0
) (
  input  logic      sclk,
  input  logic      arst_n,
  spi_lane_if.lane  bus,
  input  logic      miso,
  output logic      mosi,
  output spi_byte_t rx_byte
);

  spi_byte_t tx_sh;
  spi_byte_t rx_sh;
  logic      loaded;

  // ------------------------------------------------------------
  // transmit
  // ------------------------------------------------------------
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      tx_sh <= '0;
    end else if (bus.load) begin
      // msb hits the pin with load
      tx_sh <= bus.tx_byte[LANE];
    end else if (bus.launch) begin
      tx_sh <= {tx_sh[$bits(spi_byte_t)-2:0], 1'b0};
    end
  end

  assign mosi = tx_sh[$bits(spi_byte_t)-1];

  // ------------------------------------------------------------
  // receive
  // ------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (bus.sample) rx_sh <= {rx_sh[$bits(spi_byte_t)-2:0], miso};
  end

  assign rx_byte = rx_sh;

  // set by the first load, never cleared
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) loaded <= 1'b0;
    else if (bus.load) loaded <= 1'b1;
  end

  a_sample_after_load: assert property (@(posedge sclk) disable iff (!arst_n)
    bus.sample |-> loaded);

endmodule

/* logic/spi_frame_ctrl.sv */
// frame timing for the quad SPI master
// owns the divider, sck, chip selects and the lane strobes
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_frame_ctrl
  import spi_types_pkg::*;
  import spi_ctrl_pkg::*;
(
  input  logic      sclk,
  input  logic      arst_n,
  input  logic      start,
  input  spi_word_t tx_data,
  input  spi_sel_t  sel,
  input  logic      cpol,
  input  logic      cpha,
  output logic      sck,
  output spi_cs_t   cs_n,
  output logic      busy,
  spi_lane_if.ctrl  lanes
);

  localparam int BYTE_BITS = $bits(spi_byte_t);
  localparam int EDGES     = 2 * BYTE_BITS;
  localparam int DIV_W     = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
  localparam int EDGE_W    = $clog2(EDGES);

  spi_state_t        state;
  logic [DIV_W-1:0]  div_cnt;
  logic [EDGE_W-1:0] edge_cnt;
  spi_mode_t         mode_q;
  spi_sel_t          sel_q;
  spi_word_t         tx_q;
  logic              div_end;
  logic              accept;
  logic              tick;
  logic              leading;
  logic              load_q;
  logic              launch_q;
  logic              sample_q;
  logic              end_q;

  assign div_end = (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
  assign accept  = (state == IDLE) && start;
  // sck edge due this cycle
  assign tick    = (state == SHIFT) && div_end;
  // even edges are leading
  assign leading = ~edge_cnt[0];

  // ------------------------------------------------------------
  // state, divider and sck
  // ------------------------------------------------------------
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      div_cnt  <= '0;
      edge_cnt <= '0;
      mode_q   <= '0;
      sel_q    <= '0;
      sck      <= 1'b0;
    end else begin
      div_cnt <= div_end ? '0 : div_cnt + 1'b1;
      case (state)
        IDLE: begin
          div_cnt  <= '0;
          edge_cnt <= '0;
          if (start) begin
            state  <= SETUP;
            mode_q <= {cpol, cpha};
            sel_q  <= sel;
            // park sck at the new idle level
            sck    <= cpol;
          end
        end
        SETUP: if (div_end) state <= SHIFT;
        SHIFT: begin
          if (div_end) begin
            sck      <= ~sck;
            edge_cnt <= edge_cnt + 1'b1;
            if (edge_cnt == EDGE_W'(EDGES - 1)) state <= HOLD;
          end
        end
        HOLD: if (div_end) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // lane strobes
  // ------------------------------------------------------------
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      load_q   <= 1'b0;
      launch_q <= 1'b0;
      sample_q <= 1'b0;
      end_q    <= 1'b0;
    end else begin
      load_q   <= accept;
      end_q    <= (state == HOLD) && div_end;
      // msb already out from load, so first cpha1 and last cpha0 launch are dropped
      launch_q <= tick && (leading ? (mode_q[MODE_CPHA] && edge_cnt != '0)
                                   : (!mode_q[MODE_CPHA] && edge_cnt != EDGE_W'(EDGES - 1)));
      // cpha0 samples leading, cpha1 trailing
      sample_q <= tick && (leading ^ mode_q[MODE_CPHA]);
    end
  end

  // tx word kept for the load one cycle later
  always_ff @(posedge sclk) begin
    if (accept) tx_q <= tx_data;
  end

  assign lanes.load      = load_q;
  assign lanes.launch    = launch_q;
  assign lanes.sample    = sample_q;
  assign lanes.frame_end = end_q;

  // byte j to lane j
  for (genvar j = 0; j < `SPI_LANES; j++) begin : g_split
    assign lanes.tx_byte[j] = tx_q[j*BYTE_BITS +: BYTE_BITS];
  end

  // select low only while a frame runs
  always_comb begin
    cs_n        = '1;
    if (state != IDLE) cs_n[sel_q] = 1'b0;
  end

  assign busy = (state != IDLE);

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // at most one select low, and it holds for the whole frame
  a_one_cs: assert property (@(posedge sclk) disable iff (!arst_n)
    $onehot0(~cs_n) && (!(busy && $past(busy)) || $stable(cs_n)));
  a_idle_sck: assert property (@(posedge sclk) disable iff (!arst_n)
    (&cs_n) |-> (sck == mode_q[MODE_CPOL]));
  // strobes follow an sck edge, never both at once
  a_strobe_excl: assert property (@(posedge sclk) disable iff (!arst_n)
    (lanes.launch || lanes.sample) |-> (!(lanes.launch && lanes.sample) && $changed(sck)));

endmodule

/* logic/spi_lane_if.sv */
// strobes and lane bytes from the frame controller to the lanes
// ctrl drives, lane consumes bit strobes, drain watches frame end
`timescale 1ns/1ps
`include "spi_cfg.svh"

interface spi_lane_if
  import spi_types_pkg::*;
();

  // one-cycle pulse at frame start
  logic      load;
  // per-lane tx bytes, lane j gets byte j
  spi_byte_t tx_byte [`SPI_LANES];
  // next mosi bit out
  logic      launch;
  // shift miso in
  logic      sample;
  // one-cycle pulse after the last sample
  logic      frame_end;

  modport ctrl  (output load, tx_byte, launch, sample, frame_end);
  modport lane  (input load, tx_byte, launch, sample);
  modport drain (input frame_end);

endinterface

/* logic/spi_ctrl_pkg.sv */
// control-side types for the SPI frame controller
// state encoding and the CPOL/CPHA mode pair
package spi_ctrl_pkg;

  // frame sequencing
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SETUP = 2'd1,
    SHIFT = 2'd2,
    HOLD  = 2'd3
  } spi_state_t;

  // {cpol, cpha}
  typedef logic [1:0] spi_mode_t;

  // bit positions inside spi_mode_t
  localparam int MODE_CPOL = 1;
  localparam int MODE_CPHA = 0;

endpackage

/* logic/spi_types_pkg.sv */
// data-path types shared by the quad SPI master blocks
// import into any module that moves words, lane bytes or selects
`include "spi_cfg.svh"

package spi_types_pkg;

  // whole frame, tx or rx
  typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;

  // one lane's share of the frame
  typedef logic [`SPI_WORD_BITS/`SPI_LANES-1:0] spi_byte_t;

  // slave number
  typedef logic [$clog2(`SPI_SLAVES)-1:0] spi_sel_t;

  // chip selects, active low
  typedef logic [`SPI_SLAVES-1:0] spi_cs_t;

endpackage

/* logic/spi_cfg.svh */
// build-time sizing for the quad SPI master
// include wherever lane, word, slave or divider counts are needed
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// data lanes, one byte per lane per frame
`define SPI_LANES 4

// bits per frame across all lanes
`define SPI_WORD_BITS 32

// chip selects on the bus
`define SPI_SLAVES 4

// sclk cycles per sck half period
`define SPI_CLK_DIV 4

`endif
